// ==== sources.f ====
common/frontPkg.sv
hw/fetchAlign.sv
preDecode/preDecode.sv
hw/slotClassify.sv
hw/frontEnd.sv
sim/frontEndTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the front end testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module frontEndTb \
    -f sources.f -o frontEndSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/frontEndSim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0

// ==== sim/frontEndTb.sv ====
`timescale 1ns/1ps

module frontEndTb;
    import frontPkg::*;

    typedef logic [blockHalves-1:0][halfBits-1:0] halves_t;

    typedef struct packed {
        halfPc_t pc;
        logic [instrBits-1:0] instr;
        fetchId_t id;
        fault_t fault;
        logic taken;
        logic invalid;
        halfPc_t target;
        bHist_t hist;
        logic [2:0] cls;    // compressed, branch, jump.
    } slotItem_t;

    logic clk;
    logic rst;
    logic mispred;
    logic outEn;
    logic fetchValid;
    halfPc_t fetchPc;
    fetchId_t fetchId;
    fault_t fetchFault;
    logic fetchPredTaken;
    halfIdx_t fetchPredPos;
    halfPc_t fetchPredTarget;
    bHist_t fetchHistory;
    halves_t fetchHalves;
    logic full;

    logic [decWidth-1:0] slotValid;
    halfPc_t slotPc [decWidth];
    logic [instrBits-1:0] slotInstr [decWidth];
    fetchId_t slotId [decWidth];
    fault_t slotFault [decWidth];
    logic [decWidth-1:0] slotPredTaken;
    logic [decWidth-1:0] slotPredInvalid;
    halfPc_t slotPredTarget [decWidth];
    bHist_t slotHistory [decWidth];
    logic [decWidth-1:0] slotCompressed;
    logic [decWidth-1:0] slotBranch;
    logic [decWidth-1:0] slotJump;

    int seed = 20;
    slotItem_t expQ [$];
    slotItem_t expCur [decWidth];
    slotItem_t gotCur [decWidth];
    logic unexpected;
    logic quiet;            // no slot may be valid.
    logic pendValid;        // 32-bit start waiting for its upper half.
    halfPc_t pendPc;
    logic [halfBits-1:0] pendHalf;
    fetchId_t nextId;

    frontEnd dut0 (.*);

    always #10 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportLane(input int lane, input slotItem_t got, input slotItem_t exp);
        if (got.pc != exp.pc)
            $display("error slotPc[%0d] got %h expected %h", lane, got.pc, exp.pc);
        if (got.instr != exp.instr)
            $display("error slotInstr[%0d] got %h expected %h", lane, got.instr, exp.instr);
        if (got.id != exp.id)
            $display("error slotId[%0d] got %h expected %h", lane, got.id, exp.id);
        if (got.fault != exp.fault)
            $display("error slotFault[%0d] got %h expected %h", lane, got.fault, exp.fault);
        if (got.taken != exp.taken || got.invalid != exp.invalid)
            $display("error slotPredTaken/slotPredInvalid[%0d] got %h expected %h", lane,
                     {got.taken, got.invalid}, {exp.taken, exp.invalid});
        if (got.target != exp.target)
            $display("error slotPredTarget[%0d] got %h expected %h", lane, got.target, exp.target);
        if (got.hist != exp.hist)
            $display("error slotHistory[%0d] got %h expected %h", lane, got.hist, exp.hist);
        if (got.cls != exp.cls)
            $display("error slotCompressed/slotBranch/slotJump[%0d] got %h expected %h", lane,
                     got.cls, exp.cls);
        failRun("slot contents differ from the reference model");
    endtask

    // ============================================================
    // reference model
    // ============================================================

    function automatic logic [2:0] classBits(input logic [instrBits-1:0] ins);
        logic comp;
        logic br;
        logic jmp;
        logic [2:0] f3;
        f3 = ins[15:13];
        comp = ins[1:0] != 2'b11;
        if (comp) begin
            br = ins[1:0] == 2'b01 && f3[2:1] == 2'b11;    // c.beqz, c.bnez.
            jmp = (ins[1:0] == 2'b01 && (f3 == 3'b101 || f3 == 3'b001))
                  || (ins[1:0] == 2'b10 && f3 == 3'b100 && ins[6:2] == 5'd0 && ins[11:7] != 5'd0);
        end else begin
            br = ins[6:0] == 7'b1100011;
            jmp = ins[6:0] == 7'b1101111 || ins[6:0] == 7'b1100111;
        end
        return {comp, br, jmp};
    endfunction

    task automatic pushSlot(input halfPc_t pc, input logic [instrBits-1:0] instr,
                            input fetchId_t id, input fault_t fault, input logic taken,
                            input logic invalid, input halfPc_t target, input bHist_t hist,
                            input logic shift);
        expQ.push_back({pc, instr, id, fault, taken, invalid, target,
                        shift ? bHist_t'(hist << 1) : hist, classBits(instr)});
    endtask

    task automatic modelBlock(input halfPc_t pc, input fetchId_t id, input fault_t fault,
                              input logic taken, input halfIdx_t pos, input halfPc_t target,
                              input bHist_t hist, input halves_t hv);
        int s;
        int last;
        logic is32;
        logic bad;
        blockPc_t bpc;
        bpc = pc[$bits(halfPc_t)-1:$bits(halfIdx_t)];
        s = int'(pc[$bits(halfIdx_t)-1:0]);
        last = taken ? int'(pos) : blockHalves - 1;
        if (pendValid) begin
            pushSlot(pendPc, {hv[s], pendHalf}, id, fault, taken && pos == s, 1'b0, target,
                     hist, s > pos);
            pendValid = 1'b0;
            s++;
        end
        while (s <= last) begin
            is32 = hv[s][1:0] == 2'b11;
            bad = is32 && taken && pos == s;
            if (fault != faultNone || !is32 || bad) begin
                pushSlot({bpc, halfIdx_t'(s)}, {16'h0, hv[s]}, id, fault, taken && pos == s,
                         bad, target, hist, s > pos);
                s++;
            end else if (s == last) begin
                pendValid = 1'b1;    // joined with the next block.
                pendPc = {bpc, halfIdx_t'(s)};
                pendHalf = hv[s];
                s++;
            end else begin
                pushSlot({bpc, halfIdx_t'(s)}, {hv[s + 1], hv[s]}, id, fault,
                         taken && pos == s + 1, 1'b0, target, hist, s + 1 > pos);
                s += 2;
            end
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [halfBits-1:0] randHalf();
        int r;
        logic [halfBits-1:0] h;
        logic [6:0] ops [4];
        ops = '{7'b1100011, 7'b1101111, 7'b1100111, 7'b0110011};
        r = $random(seed);
        h = r[31:16];
        case (r[2:0])
            3'd0: h[1:0] = 2'b00;
            3'd1: h = {2'b11, r[3], h[12:2], 2'b01};
            3'd2: h = {r[3], 2'b01, h[12:2], 2'b01};
            3'd3: h = {3'b100, r[3], r[8:4] | 5'd1, 5'd0, 2'b10};
            3'd4: h[1:0] = 2'b10;
            default: h[6:0] = ops[r[4:3]];
        endcase
        return h;
    endfunction

    task automatic sendBlock(input halfPc_t pc, input fault_t fault, input logic taken,
                             input halfIdx_t pos, input bHist_t hist, input halves_t hv);
        int t;
        halfPc_t target;
        t = 0;
        target = halfPc_t'($random(seed));
        while (full) begin
            if (t == 100)
                failRun("timeout waiting for full to fall");
            step();
            t++;
        end
        fetchValid = 1'b1;
        fetchPc = pc;
        fetchId = nextId;
        fetchFault = fault;
        fetchPredTaken = taken;
        fetchPredPos = pos;
        fetchPredTarget = target;
        fetchHistory = hist;
        fetchHalves = hv;
        modelBlock(pc, nextId, fault, taken, pos, target, hist, hv);
        nextId++;
        step();
        fetchValid = 1'b0;
    endtask

    task automatic sendRandom(input fault_t fault, input logic allowTaken);
        halves_t hv;
        int r;
        int pc;
        int first;
        int pos;
        logic taken;
        for (int k = 0; k < blockHalves; k++) begin
            hv[k] = randHalf();
        end
        r = $random(seed);
        pc = $random(seed);
        first = int'(r[2:0]);
        taken = allowTaken && r[4:3] == 2'b00;
        pos = taken ? first + int'(r[10:5]) % (blockHalves - first) : int'(r[13:11]);
        sendBlock({pc[27:0], halfIdx_t'(first)}, fault, taken, halfIdx_t'(pos), r[23:16], hv);
    endtask

    // completes any straddling instruction, then waits for the model queue to empty.
    task automatic finishGroup();
        int t;
        if (pendValid)
            sendBlock(31'h0000_7f00, faultNone, 1'b0, 3'd0, 8'h00, {blockHalves{16'h0001}});
        t = 0;
        while (expQ.size() != 0) begin
            if (t == 200)
                failRun("timeout waiting for the expected slots");
            step();
            t++;
        end
        repeat (4) step();
    endtask

    // ============================================================
    // checking
    // ============================================================

    always @(negedge clk) begin
        unexpected = 1'b0;
        for (int i = 0; i < decWidth; i++) begin
            if (!rst && slotValid[i]) begin
                if (expQ.size() == 0)
                    unexpected = 1'b1;
                else
                    expCur[i] = expQ.pop_front();
            end
        end
    end

    for (genvar g = 0; g < decWidth; g++) begin : laneCheck
        assign gotCur[g] = {slotPc[g], slotInstr[g], slotId[g], slotFault[g], slotPredTaken[g],
                            slotPredInvalid[g], slotPredTarget[g], slotHistory[g],
                            slotCompressed[g], slotBranch[g], slotJump[g]};
        assert property (@(posedge clk) disable iff (rst) slotValid[g] |-> gotCur[g] == expCur[g])
            else reportLane(g, $sampled(gotCur[g]), expCur[g]);
    end

    assert property (@(posedge clk) disable iff (rst) !unexpected)
        else failRun("a slot came out that no sent block accounts for");
    assert property (@(posedge clk) disable iff (rst) quiet |-> slotValid == '0)
        else failRun("a slot was valid while output was held or flushed");

    initial begin
        halves_t hv;
        int t;
        clk = 1'b0;
        rst = 1'b1;
        mispred = 1'b0;
        outEn = 1'b1;
        fetchValid = 1'b0;
        fetchPc = '0;
        fetchId = '0;
        fetchFault = faultNone;
        fetchPredTaken = 1'b0;
        fetchPredPos = '0;
        fetchPredTarget = '0;
        fetchHistory = '0;
        fetchHalves = '0;
        unexpected = 1'b0;
        quiet = 1'b0;
        pendValid = 1'b0;
        nextId = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int b = 0; b < 12; b++) begin
            sendRandom(faultNone, 1'b1);
        end
        finishGroup();

        hv = {blockHalves{16'h4501}};
        hv[7] = 16'h10ef;    // jal start in the last halfword.
        sendBlock(31'h0000_1004, faultNone, 1'b0, 3'd0, 8'h3c, hv);
        repeat (10) step();
        hv = {blockHalves{16'h4501}};
        hv[2] = 16'h0040;
        sendBlock(31'h0000_2002, faultNone, 1'b0, 3'd0, 8'h3c, hv);
        finishGroup();

        hv[3] = 16'h0063;    // branch start at the predicted position.
        sendBlock(31'h0000_3000, faultNone, 1'b1, 3'd3, 8'h81, hv);
        hv[2] = 16'h0063;
        hv[3] = 16'h0000;
        sendBlock(31'h0000_4000, faultNone, 1'b1, 3'd3, 8'h81, hv);
        hv = {blockHalves{16'h4501}};
        sendBlock(31'h0000_5000, faultNone, 1'b0, 3'd2, 8'ha5, hv);
        finishGroup();

        sendRandom(faultAccess, 1'b0);
        sendRandom(faultPage, 1'b0);
        finishGroup();

        // ============================================================
        // back-pressure and mispredict
        // ============================================================

        outEn = 1'b0;
        repeat (3) step();
        quiet = 1'b1;
        t = 0;
        while (!full) begin
            if (t == 20)
                failRun("timeout waiting for full to rise");
            sendRandom(faultNone, 1'b1);
            t++;
        end
        repeat (5) step();
        quiet = 1'b0;
        outEn = 1'b1;
        finishGroup();

        outEn = 1'b0;
        repeat (3) step();
        quiet = 1'b1;
        sendRandom(faultNone, 1'b1);
        sendRandom(faultNone, 1'b1);
        sendRandom(faultNone, 1'b1);
        repeat (3) step();
        mispred = 1'b1;
        step();
        mispred = 1'b0;
        outEn = 1'b1;
        expQ.delete();
        pendValid = 1'b0;
        assert (!full) else failRun("full still high after a mispredict");
        repeat (6) step();
        quiet = 1'b0;
        hv = {blockHalves{16'h4501}};
        hv[6] = 16'h006f;
        hv[7] = 16'h0000;
        sendBlock(31'h0000_6005, faultNone, 1'b0, 3'd0, 8'h11, hv);
        finishGroup();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== hw/frontEnd.sv ====
`timescale 1ns/1ps

module frontEnd (
    input  logic clk,
    input  logic rst,
    input  logic mispred,
    input  logic outEn,

    input  logic fetchValid,
    input  frontPkg::halfPc_t fetchPc,
    input  frontPkg::fetchId_t fetchId,
    input  frontPkg::fault_t fetchFault,
    input  logic fetchPredTaken,
    input  frontPkg::halfIdx_t fetchPredPos,
    input  frontPkg::halfPc_t fetchPredTarget,
    input  frontPkg::bHist_t fetchHistory,
    input  logic [frontPkg::blockHalves-1:0][frontPkg::halfBits-1:0] fetchHalves,
    output logic full,

    output logic [frontPkg::decWidth-1:0] slotValid,
    output frontPkg::halfPc_t slotPc [frontPkg::decWidth],
    output logic [frontPkg::instrBits-1:0] slotInstr [frontPkg::decWidth],
    output frontPkg::fetchId_t slotId [frontPkg::decWidth],
    output frontPkg::fault_t slotFault [frontPkg::decWidth],
    output logic [frontPkg::decWidth-1:0] slotPredTaken,
    output logic [frontPkg::decWidth-1:0] slotPredInvalid,
    output frontPkg::halfPc_t slotPredTarget [frontPkg::decWidth],
    output frontPkg::bHist_t slotHistory [frontPkg::decWidth],
    output logic [frontPkg::decWidth-1:0] slotCompressed,
    output logic [frontPkg::decWidth-1:0] slotBranch,
    output logic [frontPkg::decWidth-1:0] slotJump
);
    import frontPkg::*;

    // ============================================================
    // registered fetch block
    // ============================================================

    logic blkValid;
    blockPc_t blkPc;
    fetchId_t blkId;
    fault_t blkFault;
    halfIdx_t blkFirst;
    halfIdx_t blkLast;
    halfIdx_t blkPredPos;
    logic blkPredTaken;
    halfPc_t blkPredTarget;
    bHist_t blkHistory;
    logic [blockHalves-1:0][halfBits-1:0] blkHalves;

    // ============================================================
    // predecoded lanes
    // ============================================================

    logic [decWidth-1:0] pdValid;
    halfPc_t pdPc [decWidth];
    logic [instrBits-1:0] pdInstr [decWidth];
    fetchId_t pdId [decWidth];
    fault_t pdFault [decWidth];
    logic [decWidth-1:0] pdPredTaken;
    logic [decWidth-1:0] pdPredInvalid;
    halfPc_t pdPredTarget [decWidth];
    bHist_t pdHistory [decWidth];

    fetchAlign align0 (.*);

    preDecode #(.depth(bufDepth)) split0 (.*);

    slotClassify classify0 (.*);

endmodule

// ==== hw/slotClassify.sv ====
`timescale 1ns/1ps

module slotClassify (
    input  logic clk,
    input  logic rst,
    input  logic mispred,

    input  logic [frontPkg::decWidth-1:0] pdValid,
    input  frontPkg::halfPc_t pdPc [frontPkg::decWidth],
    input  logic [frontPkg::instrBits-1:0] pdInstr [frontPkg::decWidth],
    input  frontPkg::fetchId_t pdId [frontPkg::decWidth],
    input  frontPkg::fault_t pdFault [frontPkg::decWidth],
    input  logic [frontPkg::decWidth-1:0] pdPredTaken,
    input  logic [frontPkg::decWidth-1:0] pdPredInvalid,
    input  frontPkg::halfPc_t pdPredTarget [frontPkg::decWidth],
    input  frontPkg::bHist_t pdHistory [frontPkg::decWidth],

    output logic [frontPkg::decWidth-1:0] slotValid,
    output frontPkg::halfPc_t slotPc [frontPkg::decWidth],
    output logic [frontPkg::instrBits-1:0] slotInstr [frontPkg::decWidth],
    output frontPkg::fetchId_t slotId [frontPkg::decWidth],
    output frontPkg::fault_t slotFault [frontPkg::decWidth],
    output logic [frontPkg::decWidth-1:0] slotPredTaken,
    output logic [frontPkg::decWidth-1:0] slotPredInvalid,
    output frontPkg::halfPc_t slotPredTarget [frontPkg::decWidth],
    output frontPkg::bHist_t slotHistory [frontPkg::decWidth],
    output logic [frontPkg::decWidth-1:0] slotCompressed,
    output logic [frontPkg::decWidth-1:0] slotBranch,
    output logic [frontPkg::decWidth-1:0] slotJump
);
    import frontPkg::*;

    logic [decWidth-1:0] isComp;
    logic [decWidth-1:0] isBranch;
    logic [decWidth-1:0] isJump;

    always_comb begin
        logic [1:0] quad;
        logic [6:0] op;
        logic [2:0] cf3;
        logic cJr;
        for (int i = 0; i < decWidth; i++) begin
            quad = pdInstr[i][1:0];
            op = pdInstr[i][6:0];
            cf3 = pdInstr[i][15:13];
            // c.jr and c.jalr need rs2 zero and rs1 nonzero.
            cJr = quad == quadC2 && cf3 == f3CJr && pdInstr[i][6:2] == 5'd0
                  && pdInstr[i][11:7] != 5'd0;
            isComp[i] = quad != quadFull;
            if (isComp[i]) begin
                isBranch[i] = quad == quadC1 && (cf3 == f3CBeqz || cf3 == f3CBnez);
                isJump[i] = (quad == quadC1 && (cf3 == f3CJ || cf3 == f3CJal)) || cJr;
            end else begin
                isBranch[i] = op == opBranch;
                isJump[i] = op == opJal || op == opJalr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || mispred) begin
            slotValid <= '0;
        end else begin
            slotValid <= pdValid;
        end
    end

    always_ff @(posedge clk) begin
        slotPc <= pdPc;
        slotInstr <= pdInstr;
        slotId <= pdId;
        slotFault <= pdFault;
        slotPredTaken <= pdPredTaken;
        slotPredInvalid <= pdPredInvalid;
        slotPredTarget <= pdPredTarget;
        slotHistory <= pdHistory;
        slotCompressed <= isComp;
        slotBranch <= isBranch;
        slotJump <= isJump;
    end

    // the decoder takes slots from lane 0 upwards.
    assert property (@(posedge clk) disable iff (rst)
        (slotValid & (slotValid + 1'b1)) == '0);

endmodule

// ==== preDecode/preDecode.sv ====
`timescale 1ns/1ps

module preDecode #(
    parameter int depth = frontPkg::bufDepth
) (
    input  logic clk,
    input  logic rst,
    input  logic mispred,
    input  logic outEn,

    input  logic blkValid,
    input  frontPkg::blockPc_t blkPc,
    input  frontPkg::fetchId_t blkId,
    input  frontPkg::fault_t blkFault,
    input  frontPkg::halfIdx_t blkFirst,
    input  frontPkg::halfIdx_t blkLast,
    input  frontPkg::halfIdx_t blkPredPos,
    input  logic blkPredTaken,
    input  frontPkg::halfPc_t blkPredTarget,
    input  frontPkg::bHist_t blkHistory,
    input  logic [frontPkg::blockHalves-1:0][frontPkg::halfBits-1:0] blkHalves,

    output logic full,

    output logic [frontPkg::decWidth-1:0] pdValid,
    output frontPkg::halfPc_t pdPc [frontPkg::decWidth],
    output logic [frontPkg::instrBits-1:0] pdInstr [frontPkg::decWidth],
    output frontPkg::fetchId_t pdId [frontPkg::decWidth],
    output frontPkg::fault_t pdFault [frontPkg::decWidth],
    output logic [frontPkg::decWidth-1:0] pdPredTaken,
    output logic [frontPkg::decWidth-1:0] pdPredInvalid,
    output frontPkg::halfPc_t pdPredTarget [frontPkg::decWidth],
    output frontPkg::bHist_t pdHistory [frontPkg::decWidth]
);
    import frontPkg::*;

    localparam int idxW = $clog2(depth);
    localparam int cntW = $clog2(depth + 1);

    typedef struct packed {
        blockPc_t pc;
        fetchId_t id;
        fault_t fault;
        halfIdx_t first;
        halfIdx_t last;
        halfIdx_t predPos;
        logic predTaken;
        halfPc_t predTarget;
        bHist_t history;
        logic [blockHalves-1:0][halfBits-1:0] halves;
    } entry_t;

    entry_t ring [depth];

    logic [idxW-1:0] wrIdx;
    logic [idxW-1:0] rdIdx;
    halfIdx_t subIdx;
    logic [cntW-1:0] freeCnt;

    logic [idxW-1:0] rdIdxNext;
    halfIdx_t subIdxNext;
    logic [cntW-1:0] leftNext;      // filled entries after this cycle's reads.
    logic [cntW-1:0] takenCnt;
    logic [cntW-1:0] freeNext;

    logic [decWidth-1:0] laneValid;
    halfPc_t lanePc [decWidth];
    logic [instrBits-1:0] laneInstr [decWidth];
    fetchId_t laneId [decWidth];
    fault_t laneFault [decWidth];
    logic [decWidth-1:0] laneTaken;
    logic [decWidth-1:0] laneInvalid;
    halfPc_t laneTarget [decWidth];
    bHist_t laneHist [decWidth];

    function automatic logic [idxW-1:0] nextIdx(input logic [idxW-1:0] idx);
        return (idx == idxW'(depth - 1)) ? '0 : idx + 1'b1;
    endfunction

    // ============================================================
    // instruction walk over the buffered halfwords
    // ============================================================

    always_comb begin
        entry_t cur;
        entry_t own;
        logic [idxW-1:0] idx;
        halfIdx_t sub;
        halfIdx_t endSub;
        logic [cntW-1:0] left;
        logic stall;
        logic is32;
        logic badPred;
        logic joined;
        logic straddle;
        idx = rdIdx;
        sub = subIdx;
        left = cntW'(depth) - freeCnt;
        stall = !outEn;
        takenCnt = '0;
        for (int i = 0; i < decWidth; i++) begin
            cur = ring[idx];
            is32 = cur.halves[sub][1:0] == quadFull;
            // fetch tags the second half, so a tag on the first one is a bad prediction.
            badPred = is32 && cur.predTaken && cur.predPos == sub;
            joined = is32 && !badPred && cur.fault == faultNone;
            straddle = joined && sub == cur.last;
            if (left == '0 || (straddle && left == cntW'(1))) begin
                stall = 1'b1;    // upper half not fetched yet.
            end
            own = straddle ? ring[nextIdx(idx)] : cur;
            if (straddle) begin
                endSub = own.first;
            end else if (joined) begin
                endSub = sub + 1'b1;
            end else begin
                endSub = sub;
            end
            laneValid[i] = !stall;
            lanePc[i] = {cur.pc, sub};
            laneInstr[i] = joined ? {own.halves[endSub], cur.halves[sub]}
                                  : {{halfBits{1'b0}}, cur.halves[sub]};
            laneId[i] = own.id;
            laneFault[i] = own.fault;
            laneTaken[i] = own.predTaken && own.predPos == endSub;
            laneInvalid[i] = badPred;
            laneTarget[i] = own.predTarget;
            laneHist[i] = (endSub > own.predPos)
                ? {own.history[$bits(bHist_t)-2:0], 1'b0} : own.history;
            if (!stall) begin
                if (straddle) begin
                    idx = nextIdx(idx);
                    left = left - 1'b1;
                    takenCnt = takenCnt + 1'b1;
                end
                if (endSub == own.last) begin
                    idx = nextIdx(idx);
                    left = left - 1'b1;
                    takenCnt = takenCnt + 1'b1;
                    sub = ring[idx].first;
                end else begin
                    sub = endSub + 1'b1;
                end
            end
        end
        rdIdxNext = idx;
        subIdxNext = sub;
        leftNext = left;
    end

    assign freeNext = freeCnt + takenCnt - cntW'(blkValid);

    // ============================================================
    // ring pointers and lane registers
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst || mispred) begin
            wrIdx <= '0;
            rdIdx <= '0;
            subIdx <= '0;
            freeCnt <= cntW'(depth);
            full <= 1'b0;
            pdValid <= '0;
        end else begin
            rdIdx <= rdIdxNext;
            freeCnt <= freeNext;
            full <= freeNext < cntW'(2);    // room for the block in flight.
            pdValid <= laneValid;
            if (blkValid) begin
                wrIdx <= nextIdx(wrIdx);
            end
            if (blkValid && leftNext == '0) begin
                subIdx <= blkFirst;    // new block becomes the read entry.
            end else begin
                subIdx <= subIdxNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (blkValid && !mispred) begin
            ring[wrIdx] <= '{pc: blkPc, id: blkId, fault: blkFault, first: blkFirst,
                             last: blkLast, predPos: blkPredPos, predTaken: blkPredTaken,
                             predTarget: blkPredTarget, history: blkHistory,
                             halves: blkHalves};
        end
    end

    always_ff @(posedge clk) begin
        pdPc <= lanePc;
        pdInstr <= laneInstr;
        pdId <= laneId;
        pdFault <= laneFault;
        pdPredTaken <= laneTaken;
        pdPredInvalid <= laneInvalid;
        pdPredTarget <= laneTarget;
        pdHistory <= laneHist;
    end

    // fetch has to honour full.
    assert property (@(posedge clk) disable iff (rst)
        blkValid |-> freeCnt != '0);

    assert property (@(posedge clk) disable iff (rst)
        freeCnt != cntW'(depth) |->
            subIdx >= ring[rdIdx].first && subIdx <= ring[rdIdx].last);

endmodule

// ==== hw/fetchAlign.sv ====
`timescale 1ns/1ps

module fetchAlign (
    input  logic clk,
    input  logic rst,
    input  logic mispred,

    input  logic fetchValid,
    input  frontPkg::halfPc_t fetchPc,
    input  frontPkg::fetchId_t fetchId,
    input  frontPkg::fault_t fetchFault,
    input  logic fetchPredTaken,
    input  frontPkg::halfIdx_t fetchPredPos,
    input  frontPkg::halfPc_t fetchPredTarget,
    input  frontPkg::bHist_t fetchHistory,
    input  logic [frontPkg::blockHalves-1:0][frontPkg::halfBits-1:0] fetchHalves,

    output logic blkValid,
    output frontPkg::blockPc_t blkPc,
    output frontPkg::fetchId_t blkId,
    output frontPkg::fault_t blkFault,
    output frontPkg::halfIdx_t blkFirst,
    output frontPkg::halfIdx_t blkLast,
    output frontPkg::halfIdx_t blkPredPos,
    output logic blkPredTaken,
    output frontPkg::halfPc_t blkPredTarget,
    output frontPkg::bHist_t blkHistory,
    output logic [frontPkg::blockHalves-1:0][frontPkg::halfBits-1:0] blkHalves
);
    import frontPkg::*;

    localparam int idxBits = $bits(halfIdx_t);

    halfIdx_t startIdx;
    halfIdx_t lastIdx;

    assign startIdx = fetchPc[idxBits-1:0];
    // a taken branch ends the live range at its own halfword.
    assign lastIdx = fetchPredTaken ? fetchPredPos : halfIdx_t'(blockHalves - 1);

    always_ff @(posedge clk) begin
        if (rst || mispred) begin
            blkValid <= 1'b0;    // drops the block in flight.
        end else begin
            blkValid <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            blkPc         <= fetchPc[$bits(halfPc_t)-1:idxBits];
            blkId         <= fetchId;
            blkFault      <= fetchFault;
            blkFirst      <= startIdx;
            blkLast       <= lastIdx;
            blkPredPos    <= fetchPredPos;
            blkPredTaken  <= fetchPredTaken;
            blkPredTarget <= fetchPredTarget;
            blkHistory    <= fetchHistory;
            blkHalves     <= fetchHalves;
        end
    end

    // the predictor never points in front of the fetch entry point.
    assert property (@(posedge clk) disable iff (rst)
        fetchValid && fetchPredTaken |-> fetchPredPos >= startIdx);

endmodule

// ==== common/frontPkg.sv ====
package frontPkg;

    // ============================================================
    // fetch block geometry
    // ============================================================

    localparam int blockHalves = 8;    // halfwords per fetch block.
    localparam int decWidth    = 4;    // instruction slots per cycle.
    localparam int bufDepth    = 4;    // blocks held by the predecode buffer.
    localparam int halfBits    = 16;
    localparam int instrBits   = 32;

    typedef logic [$clog2(blockHalves)-1:0] halfIdx_t;    // halfword within a block.
    typedef logic [30:0] halfPc_t;                         // pc in halfword units.
    typedef logic [$bits(halfPc_t)-$bits(halfIdx_t)-1:0] blockPc_t;

    typedef logic [4:0] fetchId_t;
    typedef logic [7:0] bHist_t;

    typedef enum logic [1:0] {
        faultNone   = 2'd0,
        faultAccess = 2'd1,
        faultPage   = 2'd2
    } fault_t;

    // ============================================================
    // opcode fields used by the class logic
    // ============================================================

    // major opcodes of the 32-bit encoding.
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    // low two bits select the quadrant, 11 marks a 32-bit instruction.
    localparam logic [1:0] quadC1   = 2'b01;
    localparam logic [1:0] quadC2   = 2'b10;
    localparam logic [1:0] quadFull = 2'b11;

    // funct3 of the compressed control transfers.
    localparam logic [2:0] f3CJal  = 3'b001;    // rv32 only.
    localparam logic [2:0] f3CJ    = 3'b101;
    localparam logic [2:0] f3CBeqz = 3'b110;
    localparam logic [2:0] f3CBnez = 3'b111;
    localparam logic [2:0] f3CJr   = 3'b100;    // c.jr and c.jalr, told apart by bit 12.

endpackage
